/* logic/ctrl_config.svh */
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// datapath widths
`define WORD_W 32
`define REG_W 5

// memory map region field of the data address
`define MMAP_HI 31
`define MMAP_LO 28

`define MMAP_DMEM 4'h1
`define MMAP_IMEM 4'h2
`define MMAP_UART 4'h8

`define UART_STAT_BIT 2 // high selects status over data

`endif

/* logic/isaPkg.sv */
`include "ctrl_config.svh"

package isaPkg;

  typedef logic [`WORD_W-1:0] wordT;
  typedef logic [`WORD_W-1:0] instrT;
  typedef logic [5:0] opcodeT;
  typedef logic [5:0] functT;
  typedef logic [`REG_W-1:0] regIdxT;

  // primary opcodes, instr[31:26]
  localparam opcodeT OP_RTYPE = 6'h00;
  localparam opcodeT OP_J = 6'h02;
  localparam opcodeT OP_JAL = 6'h03;
  localparam opcodeT OP_BEQ = 6'h04;
  localparam opcodeT OP_BNE = 6'h05;
  localparam opcodeT OP_ADDIU = 6'h09;
  localparam opcodeT OP_SLTI = 6'h0a;
  localparam opcodeT OP_ANDI = 6'h0c;
  localparam opcodeT OP_ORI = 6'h0d;
  localparam opcodeT OP_LUI = 6'h0f;
  localparam opcodeT OP_LB = 6'h20;
  localparam opcodeT OP_LH = 6'h21;
  localparam opcodeT OP_LW = 6'h23;
  localparam opcodeT OP_SB = 6'h28;
  localparam opcodeT OP_SH = 6'h29;
  localparam opcodeT OP_SW = 6'h2b;

  // funct codes for OP_RTYPE, instr[5:0]
  localparam functT FN_SLL = 6'h00;
  localparam functT FN_SRL = 6'h02;
  localparam functT FN_JR = 6'h08;
  localparam functT FN_JALR = 6'h09;
  localparam functT FN_ADDU = 6'h21;
  localparam functT FN_SUBU = 6'h23;
  localparam functT FN_AND = 6'h24;
  localparam functT FN_OR = 6'h25;
  localparam functT FN_XOR = 6'h26;
  localparam functT FN_SLT = 6'h2a;

endpackage

/* logic/ctrlPkg.sv */
package ctrlPkg;

  typedef logic [3:0] aluOpT;
  typedef logic [1:0] aluSelT;
  typedef logic [1:0] memSizeT;
  typedef logic [3:0] byteSelT;

  localparam aluOpT ALU_ADD = 4'd0;
  localparam aluOpT ALU_SUB = 4'd1;
  localparam aluOpT ALU_AND = 4'd2;
  localparam aluOpT ALU_OR = 4'd3;
  localparam aluOpT ALU_XOR = 4'd4;
  localparam aluOpT ALU_SLT = 4'd5;
  localparam aluOpT ALU_SLL = 4'd6;
  localparam aluOpT ALU_SRL = 4'd7;
  localparam aluOpT ALU_LUI = 4'd8;
  localparam aluOpT ALU_PASS = 4'd9; // operand A straight through

  localparam aluSelT SEL_PC = 2'd0;
  localparam aluSelT SEL_REG = 2'd1;
  localparam aluSelT SEL_FWD = 2'd2; // result of the previous instruction
  localparam aluSelT SEL_IMM = 2'd3;

  localparam memSizeT SZ_NONE = 2'd0;
  localparam memSizeT SZ_BYTE = 2'd1;
  localparam memSizeT SZ_HALF = 2'd2;
  localparam memSizeT SZ_WORD = 2'd3;

  typedef struct packed {
    logic regWrite;
    logic regDst; // rd rather than rt
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic branchTaken;
    logic jump;
  } ctrlSigsT;

  typedef struct packed {
    aluSelT selA;
    aluSelT selB;
  } aluSelsT;

  typedef struct packed {
    byteSelT byteSel;
    logic weIM;
    logic weDM;
    logic reUart;
    logic weUart;
    logic uartSel;
    logic rdSel; // read data comes from the UART
  } memMapT;

endpackage

/* logic/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder (
  input isaPkg::instrT instr,
  output ctrlPkg::aluOpT aluOp
);

  import isaPkg::*;
  import ctrlPkg::*;

  opcodeT opcode;
  functT funct;

  assign opcode = instr[31:26];
  assign funct = instr[5:0];

  always_comb begin
    aluOp = ALU_PASS;
    case (opcode)
      OP_RTYPE: begin
        case (funct)
          FN_ADDU: aluOp = ALU_ADD;
          FN_SUBU: aluOp = ALU_SUB;
          FN_AND: aluOp = ALU_AND;
          FN_OR: aluOp = ALU_OR;
          FN_XOR: aluOp = ALU_XOR;
          FN_SLT: aluOp = ALU_SLT;
          FN_SLL: aluOp = ALU_SLL;
          FN_SRL: aluOp = ALU_SRL;
          FN_JR,
          FN_JALR: aluOp = ALU_PASS; // jump target is rs
          default: aluOp = ALU_PASS;
        endcase
      end
      OP_ADDIU: aluOp = ALU_ADD;
      OP_ANDI: aluOp = ALU_AND;
      OP_ORI: aluOp = ALU_OR;
      OP_SLTI: aluOp = ALU_SLT;
      OP_LUI: aluOp = ALU_LUI;
      OP_LW,
      OP_LH,
      OP_LB,
      OP_SW,
      OP_SH,
      OP_SB: aluOp = ALU_ADD; // base plus offset
      OP_BEQ,
      OP_BNE: aluOp = ALU_SUB; // zero flag compares rs and rt
      OP_J,
      OP_JAL: aluOp = ALU_PASS;
      default: aluOp = ALU_PASS;
    endcase
  end

endmodule

/* logic/mainDecoder.sv */
`timescale 1ns/1ps

module mainDecoder (
  input isaPkg::instrT instr,
  input logic instrValid,
  input logic aluZero,
  output ctrlPkg::ctrlSigsT ctrl,
  output ctrlPkg::memSizeT memSize
);

  import isaPkg::*;
  import ctrlPkg::*;

  opcodeT opcode;
  functT funct;
  logic isRtype;
  logic isJr;
  logic isJalr;
  logic isImm;
  logic isLoad;
  logic isStore;

  assign opcode = instr[31:26];
  assign funct = instr[5:0];

  assign isRtype = (opcode == OP_RTYPE);
  assign isJr = isRtype && (funct == FN_JR);
  assign isJalr = isRtype && (funct == FN_JALR);
  assign isImm = (opcode == OP_ADDIU) || (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                 (opcode == OP_SLTI) || (opcode == OP_LUI);
  assign isLoad = (opcode == OP_LW) || (opcode == OP_LH) || (opcode == OP_LB);
  assign isStore = (opcode == OP_SW) || (opcode == OP_SH) || (opcode == OP_SB);

  always_comb begin
    ctrl.regWrite = instrValid &&
                    ((isRtype && !isJr) || isImm || isLoad || (opcode == OP_JAL));
    ctrl.regDst = isRtype;
    ctrl.memRead = instrValid && isLoad;
    ctrl.memWrite = instrValid && isStore;
    ctrl.memToReg = isLoad;
    ctrl.branchTaken = instrValid &&
                       (((opcode == OP_BEQ) && aluZero) || ((opcode == OP_BNE) && !aluZero));
    ctrl.jump = instrValid &&
                ((opcode == OP_J) || (opcode == OP_JAL) || isJr || isJalr);
  end

  // access width shared by loads and stores
  always_comb begin
    case (opcode)
      OP_LB,
      OP_SB: memSize = SZ_BYTE;
      OP_LH,
      OP_SH: memSize = SZ_HALF;
      OP_LW,
      OP_SW: memSize = SZ_WORD;
      default: memSize = SZ_NONE;
    endcase
  end

endmodule

/* logic/memMapDecoder.sv */
`timescale 1ns/1ps

module memMapDecoder (
  input logic memRead,
  input logic memWrite,
  input ctrlPkg::memSizeT memSize,
  input isaPkg::wordT dataAddr,
  output ctrlPkg::memMapT mmap
);

  `include "ctrl_config.svh"

  import ctrlPkg::*;

  logic [`MMAP_HI:`MMAP_LO] region;
  logic statBit;
  logic inUart;
  byteSelT laneMask;
  logic [1:0] laneShift;

  assign region = dataAddr[`MMAP_HI:`MMAP_LO];
  assign statBit = dataAddr[`UART_STAT_BIT];
  assign inUart = (region == `MMAP_UART);

  always_comb begin
    case (memSize)
      SZ_BYTE: laneMask = 4'b0001;
      SZ_HALF: laneMask = 4'b0011;
      SZ_WORD: laneMask = 4'b1111;
      default: laneMask = 4'b0000;
    endcase
  end

  // halves sit on bit 1 only, words are always aligned
  always_comb begin
    case (memSize)
      SZ_BYTE: laneShift = dataAddr[1:0];
      SZ_HALF: laneShift = {dataAddr[1], 1'b0};
      default: laneShift = 2'd0;
    endcase
  end

  always_comb begin
    mmap.byteSel = memWrite ? byteSelT'(laneMask << laneShift) : 4'b0000;
    mmap.weDM = memWrite && (region == `MMAP_DMEM);
    mmap.weIM = memWrite && (region == `MMAP_IMEM);
    mmap.weUart = memWrite && inUart && !statBit; // status register is read only
    mmap.reUart = memRead && inUart && !statBit;
    mmap.uartSel = statBit;
    mmap.rdSel = memRead && inUart;
  end

endmodule

/* logic/forwardUnit.sv */
`timescale 1ns/1ps

module forwardUnit (
  input logic clk,
  input logic rstN,
  input isaPkg::instrT instr,
  input logic instrValid,
  output ctrlPkg::aluSelsT fwd
);

  `include "ctrl_config.svh"

  import isaPkg::*;
  import ctrlPkg::*;

  opcodeT opcode;
  regIdxT rs;
  regIdxT rt;
  regIdxT curDest;
  logic curWrites;
  logic isImm;
  logic isMem;
  regIdxT prevDest;
  logic prevWrites;

  assign opcode = instr[31:26];
  assign rs = instr[25:21];
  assign rt = instr[20:16];

  assign isImm = (opcode == OP_ADDIU) || (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                 (opcode == OP_SLTI) || (opcode == OP_LUI);
  assign isMem = (opcode == OP_LW) || (opcode == OP_LH) || (opcode == OP_LB) ||
                 (opcode == OP_SW) || (opcode == OP_SH) || (opcode == OP_SB);

  always_comb begin
    curDest = '0;
    if (opcode == OP_RTYPE && instr[5:0] != FN_JR) curDest = instr[15:11];
    else if (isImm || opcode == OP_LW || opcode == OP_LH || opcode == OP_LB) curDest = rt;
    else if (opcode == OP_JAL) curDest = {`REG_W{1'b1}}; // link register
  end

  assign curWrites = (curDest != '0); // $zero is never a source to forward

  always_ff @(posedge clk) begin
    if (!rstN) begin
      prevWrites <= 1'b0;
    end else if (instrValid) begin
      prevWrites <= curWrites;
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) prevDest <= curDest; // held across stalls
  end

  always_comb begin
    if (opcode == OP_JAL) fwd.selA = SEL_PC;
    else if (prevWrites && rs == prevDest) fwd.selA = SEL_FWD;
    else fwd.selA = SEL_REG;
    if (isImm || isMem) fwd.selB = SEL_IMM;
    else if (prevWrites && rt == prevDest) fwd.selB = SEL_FWD;
    else fwd.selB = SEL_REG;
  end

endmodule

/* logic/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
  input logic clk,
  input logic rstN,
  input isaPkg::instrT instr,
  input logic instrValid,
  input logic aluZero,
  input isaPkg::wordT dataAddr,
  output ctrlPkg::ctrlSigsT ctrl,
  output ctrlPkg::aluOpT aluOp,
  output ctrlPkg::aluSelsT fwd,
  output ctrlPkg::memMapT mmap
);

  import ctrlPkg::*;

  memSizeT memSize; // load/store width into the map decoder

  mainDecoder u_mainDecoder (
    .instr(instr),
    .instrValid(instrValid),
    .aluZero(aluZero),
    .ctrl(ctrl),
    .memSize(memSize)
  );

  aluDecoder u_aluDecoder (
    .instr(instr),
    .aluOp(aluOp)
  );

  memMapDecoder u_memMapDecoder (
    .memRead(ctrl.memRead),
    .memWrite(ctrl.memWrite),
    .memSize(memSize),
    .dataAddr(dataAddr),
    .mmap(mmap)
  );

  forwardUnit u_forwardUnit (
    .clk(clk),
    .rstN(rstN),
    .instr(instr),
    .instrValid(instrValid),
    .fwd(fwd)
  );

endmodule

/* tests/ctrlChecker.sv */
`timescale 1ns/1ps

module ctrlChecker (
  input logic clk,
  input logic checkEn,
  input ctrlPkg::ctrlSigsT ctrl,
  input ctrlPkg::aluOpT aluOp,
  input ctrlPkg::aluSelsT fwd,
  input ctrlPkg::memMapT mmap,
  input ctrlPkg::ctrlSigsT expCtrl,
  input ctrlPkg::aluOpT expAluOp,
  input ctrlPkg::aluSelsT expFwd,
  input ctrlPkg::memMapT expMmap,
  output int errorCount,
  output int checkCount
);

  import ctrlPkg::*;

  int errors = 0;
  int checks = 0;

  assign errorCount = errors;
  assign checkCount = checks;

  task automatic compareField(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // outputs settle half a cycle after the rising edge that drove the row
  always @(negedge clk) begin
    if (checkEn) begin
      checks++;
      compareField("regWrite", 4'(ctrl.regWrite), 4'(expCtrl.regWrite));
      compareField("regDst", 4'(ctrl.regDst), 4'(expCtrl.regDst));
      compareField("memRead", 4'(ctrl.memRead), 4'(expCtrl.memRead));
      compareField("memWrite", 4'(ctrl.memWrite), 4'(expCtrl.memWrite));
      compareField("memToReg", 4'(ctrl.memToReg), 4'(expCtrl.memToReg));
      compareField("branchTaken", 4'(ctrl.branchTaken), 4'(expCtrl.branchTaken));
      compareField("jump", 4'(ctrl.jump), 4'(expCtrl.jump));
      compareField("aluOp", aluOp, expAluOp);
      compareField("selA", 4'(fwd.selA), 4'(expFwd.selA));
      compareField("selB", 4'(fwd.selB), 4'(expFwd.selB));
      compareField("byteSel", mmap.byteSel, expMmap.byteSel);
      compareField("weIM", 4'(mmap.weIM), 4'(expMmap.weIM));
      compareField("weDM", 4'(mmap.weDM), 4'(expMmap.weDM));
      compareField("reUart", 4'(mmap.reUart), 4'(expMmap.reUart));
      compareField("weUart", 4'(mmap.weUart), 4'(expMmap.weUart));
      compareField("uartSel", 4'(mmap.uartSel), 4'(expMmap.uartSel));
      compareField("rdSel", 4'(mmap.rdSel), 4'(expMmap.rdSel));
    end
  end

endmodule

/* tests/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb;

  import isaPkg::*;
  import ctrlPkg::*;

  typedef struct packed {
    instrT instr;
    logic instrValid;
    logic aluZero;
    wordT dataAddr;
    ctrlSigsT ctrl;
    aluOpT aluOp;
    aluSelsT fwd;
    memMapT mmap;
  } rowT;

  localparam int resetCycles = 8;
  localparam int slackCycles = 20;

  logic clk = 1'b0;
  logic rstN;
  instrT instr;
  logic instrValid;
  logic aluZero;
  wordT dataAddr;
  ctrlSigsT ctrl;
  aluOpT aluOp;
  aluSelsT fwd;
  memMapT mmap;

  logic checkEn;
  ctrlSigsT expCtrl;
  aluOpT expAluOp;
  aluSelsT expFwd;
  memMapT expMmap;
  int errorCount;
  int checkCount;
  int cycleCount = 0;
  rowT rows[$];

  always #2 clk = ~clk;

  controlUnit u_controlUnit (
    .clk(clk),
    .rstN(rstN),
    .instr(instr),
    .instrValid(instrValid),
    .aluZero(aluZero),
    .dataAddr(dataAddr),
    .ctrl(ctrl),
    .aluOp(aluOp),
    .fwd(fwd),
    .mmap(mmap)
  );

  ctrlChecker u_ctrlChecker (
    .clk(clk),
    .checkEn(checkEn),
    .ctrl(ctrl),
    .aluOp(aluOp),
    .fwd(fwd),
    .mmap(mmap),
    .expCtrl(expCtrl),
    .expAluOp(expAluOp),
    .expFwd(expFwd),
    .expMmap(expMmap),
    .errorCount(errorCount),
    .checkCount(checkCount)
  );

  function automatic instrT rIns(input functT funct, input regIdxT rd, input regIdxT rs,
                                 input regIdxT rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic instrT iIns(input opcodeT op, input regIdxT rs, input regIdxT rt,
                                 input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic instrT jIns(input opcodeT op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic addRow(input instrT ins, input logic valid, input logic zero, input wordT addr,
                        input ctrlSigsT c, input aluOpT op, input aluSelT a, input aluSelT b,
                        input memMapT m);
    rowT r;
    r.instr = ins;
    r.instrValid = valid;
    r.aluZero = zero;
    r.dataAddr = addr;
    r.ctrl = c;
    r.aluOp = op;
    r.fwd = {a, b};
    r.mmap = m;
    rows.push_back(r);
  endtask

  // ctrl bits: regWrite regDst memRead memWrite memToReg branchTaken jump
  // mmap bits: byteSel[3:0] _ weIM weDM reUart weUart uartSel rdSel
  task automatic buildTable();
    addRow(rIns(FN_ADDU, 3, 1, 2), 1, 0, 32'h0, 7'b1100000, ALU_ADD, SEL_REG, SEL_REG, 10'h0);
    addRow(rIns(FN_SUBU, 4, 3, 3), 1, 0, 32'h0, 7'b1100000, ALU_SUB, SEL_FWD, SEL_FWD, 10'h0);
    addRow(rIns(FN_AND, 5, 4, 1), 1, 0, 32'h0, 7'b1100000, ALU_AND, SEL_FWD, SEL_REG, 10'h0);
    addRow(rIns(FN_OR, 6, 1, 5), 1, 0, 32'h0, 7'b1100000, ALU_OR, SEL_REG, SEL_FWD, 10'h0);
    addRow(rIns(FN_XOR, 7, 1, 2), 1, 0, 32'h0, 7'b1100000, ALU_XOR, SEL_REG, SEL_REG, 10'h0);
    addRow(rIns(FN_SLT, 8, 1, 2), 1, 0, 32'h0, 7'b1100000, ALU_SLT, SEL_REG, SEL_REG, 10'h0);
    addRow(rIns(FN_SLL, 9, 0, 8), 1, 0, 32'h0, 7'b1100000, ALU_SLL, SEL_REG, SEL_FWD, 10'h0);
    addRow(rIns(FN_SRL, 10, 0, 2), 1, 0, 32'h0, 7'b1100000, ALU_SRL, SEL_REG, SEL_REG, 10'h0);
    addRow(iIns(OP_ADDIU, 10, 11, 5), 1, 0, 32'h0, 7'b1000000, ALU_ADD, SEL_FWD, SEL_IMM, 10'h0);
    addRow(iIns(OP_ANDI, 1, 12, 5), 1, 0, 32'h0, 7'b1000000, ALU_AND, SEL_REG, SEL_IMM, 10'h0);
    addRow(iIns(OP_ORI, 1, 13, 5), 1, 0, 32'h0, 7'b1000000, ALU_OR, SEL_REG, SEL_IMM, 10'h0);
    addRow(iIns(OP_SLTI, 13, 14, 5), 1, 0, 32'h0, 7'b1000000, ALU_SLT, SEL_FWD, SEL_IMM, 10'h0);
    addRow(iIns(OP_LUI, 0, 15, 5), 1, 0, 32'h0, 7'b1000000, ALU_LUI, SEL_REG, SEL_IMM, 10'h0);
    addRow(rIns(FN_ADDU, 0, 1, 2), 1, 0, 32'h0, 7'b1100000, ALU_ADD, SEL_REG, SEL_REG, 10'h0);
    addRow(rIns(FN_ADDU, 16, 0, 0), 1, 0, 32'h0, 7'b1100000, ALU_ADD, SEL_REG, SEL_REG, 10'h0);
    addRow(jIns(OP_JAL, 26'h10), 1, 0, 32'h0, 7'b1000001, ALU_PASS, SEL_PC, SEL_REG, 10'h0);
    addRow(rIns(FN_JR, 0, 31, 0), 1, 0, 32'h0, 7'b0100001, ALU_PASS, SEL_FWD, SEL_REG, 10'h0);
    addRow(rIns(FN_JALR, 31, 1, 0), 1, 0, 32'h0, 7'b1100001, ALU_PASS, SEL_REG, SEL_REG, 10'h0);
    addRow(jIns(OP_J, 26'h0), 1, 0, 32'h0, 7'b0000001, ALU_PASS, SEL_REG, SEL_REG, 10'h0);
    addRow(iIns(OP_BEQ, 1, 2, 4), 1, 1, 32'h0, 7'b0000010, ALU_SUB, SEL_REG, SEL_REG, 10'h0);
    addRow(iIns(OP_BEQ, 1, 2, 4), 1, 0, 32'h0, 7'b0000000, ALU_SUB, SEL_REG, SEL_REG, 10'h0);
    addRow(iIns(OP_BNE, 1, 2, 4), 1, 1, 32'h0, 7'b0000000, ALU_SUB, SEL_REG, SEL_REG, 10'h0);
    addRow(iIns(OP_BNE, 1, 2, 4), 1, 0, 32'h0, 7'b0000010, ALU_SUB, SEL_REG, SEL_REG, 10'h0);
    addRow(iIns(OP_SB, 1, 2, 0), 1, 0, 32'h1000_0000, 7'b0001000, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b0001_010000);
    addRow(iIns(OP_SB, 1, 2, 0), 1, 0, 32'h1000_0001, 7'b0001000, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b0010_010000);
    addRow(iIns(OP_SB, 1, 2, 0), 1, 0, 32'h1000_0002, 7'b0001000, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b0100_010000);
    addRow(iIns(OP_SB, 1, 2, 0), 1, 0, 32'h1000_0003, 7'b0001000, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b1000_010000);
    addRow(iIns(OP_SH, 1, 2, 0), 1, 0, 32'h1000_0000, 7'b0001000, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b0011_010000);
    addRow(iIns(OP_SH, 1, 2, 0), 1, 0, 32'h1000_0002, 7'b0001000, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b1100_010000);
    addRow(iIns(OP_SW, 1, 2, 0), 1, 0, 32'h1000_0008, 7'b0001000, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b1111_010000);
    addRow(iIns(OP_SW, 1, 2, 0), 1, 0, 32'h2000_0010, 7'b0001000, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b1111_100000); // instruction memory
    addRow(iIns(OP_SW, 1, 2, 0), 1, 0, 32'h8000_0000, 7'b0001000, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b1111_000100); // uart data
    addRow(iIns(OP_SW, 1, 2, 0), 1, 0, 32'h8000_0004, 7'b0001000, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b1111_000010); // uart status, not writable
    addRow(iIns(OP_LW, 1, 24, 0), 1, 0, 32'h2000_0000, 7'b1010100, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b0000_000000); // no enable for instruction memory reads
    addRow(iIns(OP_LW, 1, 17, 0), 1, 0, 32'h1000_0000, 7'b1010100, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b0000_000000);
    addRow(iIns(OP_LH, 17, 18, 0), 1, 0, 32'h8000_0000, 7'b1010100, ALU_ADD,
           SEL_FWD, SEL_IMM, 10'b0000_001001);
    addRow(iIns(OP_LB, 1, 19, 0), 1, 0, 32'h8000_0004, 7'b1010100, ALU_ADD,
           SEL_REG, SEL_IMM, 10'b0000_000011);
    // stalls keep r19 as the forwarding source
    addRow(iIns(OP_SW, 19, 2, 0), 0, 0, 32'h1000_0000, 7'b0000000, ALU_ADD,
           SEL_FWD, SEL_IMM, 10'b0000_000000);
    addRow(rIns(FN_ADDU, 20, 1, 2), 0, 0, 32'h0, 7'b0100000, ALU_ADD, SEL_REG, SEL_REG, 10'h0);
    addRow(rIns(FN_ADDU, 21, 19, 19), 1, 0, 32'h0, 7'b1100000, ALU_ADD, SEL_FWD, SEL_FWD, 10'h0);
    addRow(iIns(OP_LW, 21, 22, 0), 0, 0, 32'h8000_0004, 7'b0000100, ALU_ADD,
           SEL_FWD, SEL_IMM, 10'b0000_000010);
    addRow(iIns(OP_BEQ, 21, 3, 4), 0, 1, 32'h0, 7'b0000000, ALU_SUB, SEL_FWD, SEL_REG, 10'h0);
    addRow(jIns(OP_JAL, 26'h0), 0, 0, 32'h0, 7'b0000000, ALU_PASS, SEL_PC, SEL_REG, 10'h0);
    addRow(rIns(FN_AND, 23, 2, 21), 1, 0, 32'h0, 7'b1100000, ALU_AND, SEL_REG, SEL_FWD, 10'h0);
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= resetCycles + rows.size() + slackCycles) begin
      $display("timeout: the run did not finish within %0d cycles", cycleCount);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    rstN = 1'b0;
    instr = rIns(FN_ADDU, 1, 2, 3); // leaves r1 in prevDest while reset holds prevWrites low
    instrValid = 1'b1;
    aluZero = 1'b0;
    dataAddr = '0;
    checkEn = 1'b0;
    expCtrl = '0;
    expAluOp = '0;
    expFwd = '0;
    expMmap = '0;
    buildTable();
    repeat (resetCycles - 1) @(posedge clk);
    instrValid <= 1'b0;
    @(posedge clk);
    rstN <= 1'b1;
    foreach (rows[i]) begin
      @(posedge clk);
      instr <= rows[i].instr;
      instrValid <= rows[i].instrValid;
      aluZero <= rows[i].aluZero;
      dataAddr <= rows[i].dataAddr;
      expCtrl <= rows[i].ctrl;
      expAluOp <= rows[i].aluOp;
      expFwd <= rows[i].fwd;
      expMmap <= rows[i].mmap;
      checkEn <= 1'b1;
    end
    @(posedge clk);
    checkEn <= 1'b0;
    instrValid <= 1'b0;
    @(posedge clk);
    if (checkCount != rows.size()) begin
      $display("only %0d of %0d rows were checked", checkCount, rows.size());
    end
    $display("summary: %0d errors over %0d checked rows", errorCount, checkCount);
    if (errorCount == 0 && checkCount == rows.size()) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+logic
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/aluDecoder.sv
logic/mainDecoder.sv
logic/memMapDecoder.sv
logic/forwardUnit.sv
logic/controlUnit.sv
tests/ctrlChecker.sv
tests/controlUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= controlUnitTb
FLAGS ?= --binary --timing --timescale 1ns/1ps
OBJ_DIR ?= obj_dir
PASS_MSG = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "variables: VERILATOR TOP FLAGS OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f files.f -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
